// File: Makefile
TOP = tb_aes_encipher

sim:
	verilator --binary --top-module $(TOP) -f aes_encipher.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

//--------------------------------------------------------------------
// Block and key geometry
//--------------------------------------------------------------------
`define AES_BLOCK_W 128
`define AES_KEY_W   128
`define AES_WORD_W  32

// AES-128 only, ten rounds after the initial key addition
`define AES_NUM_ROUNDS 10

// Result slots the consumer may grant ahead of any result
`define AES_OUT_CREDITS_MAX 2

`endif

// File: aes_credit_port.sv
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_credit_port
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       done,
  input  aes_block_t result,
  output logic       hold_free,
  output logic       in_credit,
  input  logic       out_credit,
  output logic       out_valid,
  output aes_block_t out_block
);

  localparam int CNT_W = $clog2(`AES_OUT_CREDITS_MAX + 1);

  aes_block_t       hold_reg;
  logic             full_reg;
  logic [CNT_W-1:0] credit_reg;
  logic             valid_reg;
  logic             boot_arm_reg;
  logic             boot_credit_reg;
  logic             send;

  //------------------------------------------------------------------
  // Output side
  //------------------------------------------------------------------
  // Result leaves once a slot has been granted
  assign send      = full_reg && (credit_reg != '0);
  assign hold_free = !full_reg;
  assign out_valid = valid_reg;
  // Stays stable through the out_valid cycle, reload needs hold_free
  assign out_block = hold_reg;

  // One credit back to the sender per finished block,
  // plus the single boot credit
  assign in_credit = boot_credit_reg | done;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      full_reg        <= 1'b0;
      credit_reg      <= '0;
      valid_reg       <= 1'b0;
      boot_arm_reg    <= 1'b1;
      boot_credit_reg <= 1'b0;
    end
    else
    begin
      // Boot pulse in the first cycle out of reset
      boot_arm_reg    <= 1'b0;
      boot_credit_reg <= boot_arm_reg;
      valid_reg       <= send;
      credit_reg      <= credit_reg + CNT_W'(out_credit) - CNT_W'(send);
      if (done)
        full_reg <= 1'b1;
      else if (send)
        full_reg <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (done)
      hold_reg <= result;
  end

endmodule

// File: aes_encipher.f
+incdir+.
aes_pkg.sv
aes_sbox_word.sv
aes_key_schedule.sv
aes_round_datapath.sv
aes_encipher_ctrl.sv
aes_credit_port.sv
aes_encipher_top.sv
tb_aes_encipher.sv

// File: aes_encipher_ctrl.sv
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_encipher_ctrl
  import aes_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start,
  input  logic        hold_free,
  output round_ctrl_t round_ctrl,
  output logic        key_load,
  output logic        key_step,
  output logic        done
);

  enc_state_t state_reg;
  enc_state_t state_new;
  enc_state_t state_cur;
  logic [1:0] sword_reg;
  logic [1:0] sword_new;
  logic [3:0] round_reg;
  logic [3:0] round_new;

  //------------------------------------------------------------------
  // State and counter registers
  //------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= ENC_IDLE;
      sword_reg <= 2'd0;
      round_reg <= 4'd0;
    end
    else
    begin
      state_reg <= state_new;
      sword_reg <= sword_new;
      round_reg <= round_new;
    end
  end

  // The request payload is only present with start,
  // so idle falls straight into the init cycle
  always_comb
  begin
    state_cur = state_reg;
    if ((state_reg == ENC_IDLE) && start)
      state_cur = ENC_INIT;
  end

  //------------------------------------------------------------------
  // Sequencing
  //------------------------------------------------------------------
  always_comb
  begin
    state_new        = state_cur;
    sword_new        = sword_reg;
    round_new        = round_reg;
    round_ctrl.op    = OP_NONE;
    round_ctrl.sword = sword_reg;
    key_load         = 1'b0;
    key_step         = 1'b0;
    done             = 1'b0;

    case (state_cur)
      ENC_INIT:
      begin
        round_ctrl.op = OP_INIT;
        key_load      = 1'b1;
        sword_new     = 2'd0;
        round_new     = 4'd1;
        state_new     = ENC_SBOX;
      end
      ENC_SBOX:
      begin
        round_ctrl.op = OP_SBOX;
        // Round key ready well before the mixing cycle
        key_step      = (sword_reg == 2'd0);
        sword_new     = sword_reg + 2'd1;
        if (sword_reg == 2'd3)
          state_new = (round_reg == 4'(`AES_NUM_ROUNDS)) ? ENC_FINAL : ENC_MAIN;
      end
      ENC_MAIN:
      begin
        round_ctrl.op = OP_MAIN;
        round_new     = round_reg + 4'd1;
        state_new     = ENC_SBOX;
      end
      ENC_FINAL:
      begin
        // Last round skips MixColumns
        round_ctrl.op = OP_FINAL;
        state_new     = ENC_HOLD;
      end
      ENC_HOLD:
      begin
        // Wait for the output stage to take the result
        if (hold_free)
        begin
          done      = 1'b1;
          state_new = ENC_IDLE;
        end
      end
      default:
        state_new = ENC_IDLE;
    endcase
  end

endmodule

// File: aes_encipher_top.sv
`timescale 1ns/1ps

module aes_encipher_top
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       in_valid,
  input  aes_req_t   in_req,
  output logic       in_credit,
  input  logic       out_credit,
  output logic       out_valid,
  output aes_block_t out_block
);

  round_ctrl_t round_ctrl;
  logic        key_load;
  logic        key_step;
  logic        done;
  logic        hold_free;
  aes_block_t  round_key;
  aes_block_t  state;
  aes_word_t   sbox_in;
  aes_word_t   sbox_out;

  //------------------------------------------------------------------
  // Core sequencing
  //------------------------------------------------------------------
  // A credit-backed request starts the FSM directly
  aes_encipher_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (in_valid),
    .hold_free  (hold_free),
    .round_ctrl (round_ctrl),
    .key_load   (key_load),
    .key_step   (key_step),
    .done       (done)
  );

  // Cipher key goes to both the initial XOR and the key schedule
  aes_round_datapath u_datapath (
    .clk        (clk),
    .reset_n    (reset_n),
    .round_ctrl (round_ctrl),
    .block_in   (in_req.block),
    .key_in     (in_req.key),
    .round_key  (round_key),
    .sbox_in    (sbox_in),
    .sbox_out   (sbox_out),
    .state      (state)
  );

  aes_key_schedule u_key_schedule (
    .clk       (clk),
    .reset_n   (reset_n),
    .key_load  (key_load),
    .key_in    (in_req.key),
    .key_step  (key_step),
    .round_key (round_key)
  );

  // Shared word S-box for SubBytes
  aes_sbox_word u_sbox (
    .in_word  (sbox_in),
    .out_word (sbox_out)
  );

  //------------------------------------------------------------------
  // Flow control and output stage
  //------------------------------------------------------------------
  aes_credit_port u_credit_port (
    .clk        (clk),
    .reset_n    (reset_n),
    .done       (done),
    .result     (state),
    .hold_free  (hold_free),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_block  (out_block)
  );

endmodule

// File: aes_key_schedule.sv
`timescale 1ns/1ps

module aes_key_schedule
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       key_load,
  input  aes_block_t key_in,
  input  logic       key_step,
  output aes_block_t round_key
);

  aes_block_t key_reg;
  aes_block_t key_next;
  logic [7:0] rcon_reg;
  aes_word_t  rot_word;
  aes_word_t  sub_word;
  aes_word_t  w0;
  aes_word_t  w1;
  aes_word_t  w2;
  aes_word_t  w3;

  //------------------------------------------------------------------
  // Next round key, computed from the current one
  //------------------------------------------------------------------
  // RotWord on the last word of the key
  assign rot_word = {key_reg[23:0], key_reg[31:24]};

  // Private S-box, the datapath owns the shared one
  aes_sbox_word u_sbox (
    .in_word  (rot_word),
    .out_word (sub_word)
  );

  // XOR chain across the four words
  always_comb
  begin
    w0       = key_reg[127:96] ^ sub_word ^ {rcon_reg, 24'h000000};
    w1       = key_reg[95:64] ^ w0;
    w2       = key_reg[63:32] ^ w1;
    w3       = key_reg[31:0] ^ w2;
    key_next = {w0, w1, w2, w3};
  end

  //------------------------------------------------------------------
  // Registers
  //------------------------------------------------------------------
  // Round constant, doubled in GF(2^8) after each step
  always_ff @(posedge clk)
  begin
    if (!reset_n || key_load)
      rcon_reg <= 8'h01;
    else if (key_step)
      rcon_reg <= {rcon_reg[6:0], 1'b0} ^ (8'h1b & {8{rcon_reg[7]}});
  end

  // Cipher key on load, then one round key per step
  always_ff @(posedge clk)
  begin
    if (key_load)
      key_reg <= key_in;
    else if (key_step)
      key_reg <= key_next;
  end

  assign round_key = key_reg;

endmodule

// File: aes_pkg.sv
`include "aes_config.svh"

package aes_pkg;

  //------------------------------------------------------------------
  // Data types
  //------------------------------------------------------------------
  // Full state or round key, byte 0 in the top bits
  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

  // One column of the state
  typedef logic [`AES_WORD_W-1:0] aes_word_t;

  // Input payload, key in the upper half
  typedef struct packed {
    logic [`AES_KEY_W-1:0] key;
    aes_block_t            block;
  } aes_req_t;

  //------------------------------------------------------------------
  // Control types
  //------------------------------------------------------------------
  typedef enum logic [2:0] {
    ENC_IDLE,
    ENC_INIT,
    ENC_SBOX,
    ENC_MAIN,
    ENC_FINAL,
    ENC_HOLD
  } enc_state_t;

  // State register update selected per cycle
  typedef enum logic [2:0] {
    OP_NONE,
    OP_INIT,
    OP_SBOX,
    OP_MAIN,
    OP_FINAL
  } round_op_t;

  // Opcode plus the word index used during SubBytes
  typedef struct packed {
    round_op_t  op;
    logic [1:0] sword;
  } round_ctrl_t;

endpackage

// File: aes_round_datapath.sv
`timescale 1ns/1ps

module aes_round_datapath
  import aes_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  round_ctrl_t round_ctrl,
  input  aes_block_t  block_in,
  input  aes_block_t  key_in,
  input  aes_block_t  round_key,
  output aes_word_t   sbox_in,
  input  aes_word_t   sbox_out,
  output aes_block_t  state
);

  //------------------------------------------------------------------
  // GF(2^8) helpers for MixColumns
  //------------------------------------------------------------------
  function automatic logic [7:0] gm2(input logic [7:0] op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  function automatic logic [7:0] gm3(input logic [7:0] op);
    return gm2(op) ^ op;
  endfunction

  // Byte (row r, column c) sits at index r + 4c from the top
  function automatic aes_block_t shift_rows(input aes_block_t blk);
    aes_block_t res;
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        // Row r rotates left by r columns
        res[127 - 8*(4*c + r) -: 8] = blk[127 - 8*(4*((c + r) % 4) + r) -: 8];
      end
    end
    return res;
  endfunction

  function automatic aes_word_t mix_column(input aes_word_t col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {gm2(a0) ^ gm3(a1) ^ a2 ^ a3,
            a0 ^ gm2(a1) ^ gm3(a2) ^ a3,
            a0 ^ a1 ^ gm2(a2) ^ gm3(a3),
            gm3(a0) ^ a1 ^ a2 ^ gm2(a3)};
  endfunction

  aes_word_t  word_reg [4];
  aes_block_t shifted;
  aes_block_t mixed;
  aes_block_t state_new;

  assign state   = {word_reg[0], word_reg[1], word_reg[2], word_reg[3]};
  // Word under substitution goes to the shared S-box
  assign sbox_in = word_reg[round_ctrl.sword];

  always_comb
  begin
    shifted = shift_rows(state);
    for (int c = 0; c < 4; c++)
    begin
      mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
    end
  end

  // Next state per opcode with OP_NONE holding the state
  always_comb
  begin
    state_new = state;
    case (round_ctrl.op)
      OP_INIT:  state_new = block_in ^ key_in;
      OP_SBOX:  state_new[127 - 32*round_ctrl.sword -: 32] = sbox_out;
      OP_MAIN:  state_new = mixed ^ round_key;
      OP_FINAL: state_new = shifted ^ round_key;
      default:  state_new = state;
    endcase
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      if (!reset_n)
        word_reg[i] <= '0;
      else
        word_reg[i] <= state_new[127 - 32*i -: 32];
    end
  end

endmodule

// File: aes_sbox_word.sv
`timescale 1ns/1ps

module aes_sbox_word
  import aes_pkg::*;
(
  input  aes_word_t in_word,
  output aes_word_t out_word
);

  // Forward S-box, indexed by the input byte
  localparam logic [7:0] SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Four independent byte lookups
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      out_word[8*i +: 8] = SBOX[in_word[8*i +: 8]];
    end
  end

endmodule

// File: tb_aes_encipher.sv
`timescale 1ns/1ps
`include "aes_config.svh"

module tb_aes_encipher
  import aes_pkg::*;
();

  // Known-answer entry
  typedef struct packed {
    aes_block_t key;
    aes_block_t plain;
    aes_block_t cipher;
  } vector_t;

  localparam int NUM_VECTORS  = 4;
  // From the in_valid sample to the out_valid sample
  localparam int LATENCY      = 53;
  localparam int STALL_CYCLES = 200;
  // Latency check, two stalled requests, then the whole table
  localparam int NUM_REQS     = NUM_VECTORS + 3;
  localparam int WATCHDOG_CYCLES = NUM_REQS * (LATENCY + 16) + STALL_CYCLES + 200;

  // FIPS-197 C.1, FIPS-197 B, SP 800-38A ECB block 1, all-zero key and block
  localparam vector_t VECTORS [NUM_VECTORS] = '{
    '{128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
      128'h69c4e0d86a7b0430d8cdb78070b4c55a},
    '{128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
      128'h3925841d02dc09fbdc118597196a0b32},
    '{128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h6bc1bee22e409f96e93d7e117393172a,
      128'h3ad77bb40d7a3660a89ecaf32466ef97},
    '{128'h00000000000000000000000000000000, 128'h00000000000000000000000000000000,
      128'h66e94bd4ef8a2c3b884cfa59ca342b2e}
  };

  logic       clk;
  logic       reset_n;
  logic       in_valid;
  aes_req_t   in_req;
  logic       in_credit;
  logic       out_credit;
  logic       out_valid;
  aes_block_t out_block;

  // Bookkeeping shared by the stimulus and the monitor
  int          cycle_cnt;
  int          credit_in_cnt;
  int          credits_used;
  int          out_cnt;
  int          out_granted;
  int          send_cycle;
  int          out_cycle;
  logic [31:0] lfsr;
  aes_block_t  exp_q [$];

  aes_encipher_top u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_block  (out_block)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] time %0t: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Four bits with one LFSR step each give 0 to 15 cycles
  task automatic random_delay(output int cycles);
    cycles = 0;
    for (int i = 0; i < 4; i++)
    begin
      lfsr   = lfsr_step(lfsr);
      cycles = (cycles << 1) | int'(lfsr[0]);
    end
  endtask

  // Spends one input credit on one table entry
  task automatic send_request(input int idx);
    @(posedge clk);
    while (credit_in_cnt == credits_used)
      @(posedge clk);
    #1;
    in_valid     = 1'b1;
    in_req.key   = VECTORS[idx].key;
    in_req.block = VECTORS[idx].plain;
    credits_used = credits_used + 1;
    exp_q.push_back(VECTORS[idx].cipher);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // One-cycle out_credit pulse
  task automatic grant_credit();
    @(posedge clk);
    #1;
    out_credit  = 1'b1;
    out_granted = out_granted + 1;
    @(posedge clk);
    #1;
    out_credit = 1'b0;
  endtask

  task automatic wait_outputs(input int count);
    while (out_cnt < count)
      @(posedge clk);
  endtask

  //--------------------------------------------------------------------
  // Monitor sampling mid-cycle
  //--------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      if (in_credit)
        credit_in_cnt = credit_in_cnt + 1;
      if (in_valid)
        send_cycle = cycle_cnt;
      if (out_valid)
      begin
        out_cnt   = out_cnt + 1;
        out_cycle = cycle_cnt;
        check_value(128'(out_cnt <= out_granted), 128'(1), "out_valid without a credit");
        check_value(128'(exp_q.size() != 0), 128'(1), "result with no request pending");
        // Queue order is request order
        check_value(out_block, exp_q.pop_front(), "ciphertext");
      end
    end
  end

  //--------------------------------------------------------------------
  // Watchdog
  //--------------------------------------------------------------------
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Test timed out after %0d clock cycles without finishing", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial
  begin
    int credits_before;
    int outs_before;
    int delay;

    clk           = 1'b0;
    reset_n       = 1'b0;
    in_valid      = 1'b0;
    in_req        = '0;
    out_credit    = 1'b0;
    cycle_cnt     = 0;
    credit_in_cnt = 0;
    credits_used  = 0;
    out_cnt       = 0;
    out_granted   = 0;
    send_cycle    = 0;
    out_cycle     = 0;
    lfsr          = 32'h63b2;

    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Only the boot credit appears and nothing comes out
    repeat (10) @(posedge clk);
    check_value(128'(credit_in_cnt), 128'(1), "in_credit pulses after reset");
    check_value(128'(out_cnt), 128'(0), "out_valid pulses after reset");

    // Credit granted ahead gives the fixed latency
    grant_credit();
    send_request(0);
    wait_outputs(1);
    check_value(128'(out_cycle - send_cycle), 128'(LATENCY), "in_valid to out_valid cycles");

    // Two requests fit without output credits before the input side stalls
    send_request(1);
    send_request(2);
    credits_before = credit_in_cnt;
    outs_before    = out_cnt;
    repeat (LATENCY + STALL_CYCLES) @(posedge clk);
    check_value(128'(credit_in_cnt), 128'(credits_before), "in_credit while stalled");
    check_value(128'(out_cnt), 128'(outs_before), "out_valid while stalled");
    grant_credit();
    grant_credit();
    wait_outputs(3);

    // Whole table with random credit return
    fork
      begin
        for (int i = 0; i < NUM_VECTORS; i++)
          send_request(i);
      end
      begin
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
          random_delay(delay);
          repeat (delay) @(posedge clk);
          // Keep outstanding credits within the limit
          while (out_granted - out_cnt >= `AES_OUT_CREDITS_MAX)
            @(posedge clk);
          grant_credit();
        end
      end
    join
    wait_outputs(3 + NUM_VECTORS);

    repeat (5) @(posedge clk);
    // Boot credit plus one per finished block
    check_value(128'(credit_in_cnt), 128'(credits_used + 1), "in_credit pulses in total");
    $display("Verification passed");
    $finish;
  end

endmodule
